// ==== fp_fmt_pkg.sv ====
// Floating-point format package
// FP32/FP16 widths, canonical NaNs, exception flags and the shared data word views
package fp_fmt_pkg;

  // ---------------------------------------------------------------------------
  // Formats
  // ---------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // Canonical quiet NaNs as defined by the RISC-V F and Zfh extensions
  localparam logic [FP32_WIDTH-1:0] FP32_CANON_NAN = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_CANON_NAN = 16'h7e00;

  // ---------------------------------------------------------------------------
  // Exception flags
  // ---------------------------------------------------------------------------
  // Same bit order as the fflags CSR, nv is the MSB
  typedef struct packed {
    logic nv;
    logic dz;
    logic of_;
    logic uf;
    logic nx;
  } status_t;

  // ---------------------------------------------------------------------------
  // Data word
  // ---------------------------------------------------------------------------
  // Two FP16 values side by side, lo is lane 0
  typedef struct packed {
    logic [FP16_WIDTH-1:0] hi;
    logic [FP16_WIDTH-1:0] lo;
  } fp16_pair_t;

  // One 32-bit word seen either as a single FP32 value or as two FP16 lanes
  typedef union packed {
    logic [FP32_WIDTH-1:0] fp32;
    fp16_pair_t            fp16;
  } fp_word_u;

endpackage

// ==== minmax_slice_pkg.sv ====
// Min/max slice configuration package
// Data width, lane count, operation encoding and the lane 0 side information
package minmax_slice_pkg;

  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 2;

  // RISC-V FMIN/FMAX selection
  typedef enum logic {
    MIN = 1'b0,
    MAX = 1'b1
  } minmax_op_e;

  // Side information carried through the lane 0 stage
  // Needed at the output to pack the result word
  typedef struct packed {
    fp_fmt_pkg::fp_format_e fmt;
    logic                   vectorial;
  } aux_t;

endpackage

// ==== slice_operand_split.sv ====
// Operand splitter for the min/max slice
// Cuts both operands into lane operands and checks NaN boxing of scalar FP16
`timescale 1ns/1ps

module slice_operand_split (
  input  fp_fmt_pkg::fp_word_u                 op_a_i,
  input  fp_fmt_pkg::fp_word_u                 op_b_i,
  input  fp_fmt_pkg::fp_format_e               fmt_i,
  input  logic                                 vectorial_i,
  output logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane0_a_o,
  output logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane0_b_o,
  output logic [fp_fmt_pkg::FP16_WIDTH-1:0]    lane1_a_o,
  output logic [fp_fmt_pkg::FP16_WIDTH-1:0]    lane1_b_o
);

  logic is_fp16;
  logic scalar_fp16;

  // Lane 0 operand for one input word
  function automatic logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane0_operand(
    input fp_fmt_pkg::fp_word_u word,
    input logic                 fp16,
    input logic                 check_box
  );
    logic [fp_fmt_pkg::FP16_WIDTH-1:0] half;
    half = word.fp16.lo;
    // An FP16 value without all ones above it is read as the canonical NaN
    if (check_box && (word.fp16.hi != '1)) begin
      half = fp_fmt_pkg::FP16_CANON_NAN;
    end
    if (fp16) begin
      lane0_operand = {{fp_fmt_pkg::FP16_WIDTH{1'b0}}, half};
    end else begin
      lane0_operand = word.fp32;
    end
  endfunction

  // The vectorial flag only means something for FP16
  assign is_fp16     = (fmt_i == fp_fmt_pkg::FP16);
  assign scalar_fp16 = is_fp16 & ~vectorial_i;

  assign lane0_a_o = lane0_operand(op_a_i, is_fp16, scalar_fp16);
  assign lane0_b_o = lane0_operand(op_b_i, is_fp16, scalar_fp16);

  // Upper halves feed lane 1, which only runs for vectorial FP16
  assign lane1_a_o = op_a_i.fp16.hi;
  assign lane1_b_o = op_b_i.fp16.hi;

endmodule

// ==== fp_minmax_lane.sv ====
// Single min/max lane
// Compares two FP32 or FP16 values with RISC-V NaN rules and registers the result
`timescale 1ns/1ps

module fp_minmax_lane #(
  parameter bit HasFp32 = 1'b1
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [31:0]                   a_i,
  input  logic [31:0]                   b_i,
  input  minmax_slice_pkg::minmax_op_e  op_i,
  input  fp_fmt_pkg::fp_format_e        fmt_i,
  input  logic [1:0]                    aux_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  output logic [31:0]                   result_o,
  output fp_fmt_pkg::status_t           status_o,
  output logic [1:0]                    aux_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i
);

  logic                 is_fp32;
  logic [1:0][31:0]     opnd;
  logic [1:0]           sign;
  logic [1:0][30:0]     mag;
  logic [1:0]           is_zero;
  logic [1:0]           is_nan;
  logic [1:0]           is_snan;
  logic                 a_lt_b;
  logic [31:0]          canon_nan;
  logic [31:0]          result_d;
  fp_fmt_pkg::status_t  status_d;

  logic                 valid_q;
  logic                 load;
  logic [31:0]          result_q;
  fp_fmt_pkg::status_t  status_q;
  logic [1:0]           aux_q;

  // A lane built without FP32 treats every operand as FP16
  assign is_fp32 = HasFp32 && (fmt_i == fp_fmt_pkg::FP32);
  assign opnd    = {b_i, a_i};

  // ---------------------------------------------------------------------------
  // Operand classification
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (is_fp32) begin
        sign[i]    = opnd[i][31];
        mag[i]     = opnd[i][30:0];
        is_nan[i]  = (&opnd[i][30:23]) & (|opnd[i][22:0]);
        is_snan[i] = is_nan[i] & ~opnd[i][22];
      end else begin
        sign[i]    = opnd[i][15];
        mag[i]     = {16'h0000, opnd[i][14:0]};
        is_nan[i]  = (&opnd[i][14:10]) & (|opnd[i][9:0]);
        is_snan[i] = is_nan[i] & ~opnd[i][9];
      end
      is_zero[i] = (mag[i] == '0);
    end
  end

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin
    if (is_zero[0] && is_zero[1]) begin
      a_lt_b = sign[0] & ~sign[1];
    end else if (sign[0] != sign[1]) begin
      a_lt_b = sign[0];
    end else if (sign[0]) begin
      a_lt_b = (mag[0] > mag[1]);
    end else begin
      a_lt_b = (mag[0] < mag[1]);
    end
  end

  assign canon_nan = is_fp32 ? fp_fmt_pkg::FP32_CANON_NAN
                             : {16'h0000, fp_fmt_pkg::FP16_CANON_NAN};

  // ---------------------------------------------------------------------------
  // Selection with NaN rules
  // ---------------------------------------------------------------------------
  always_comb begin
    if (is_nan[0] && is_nan[1]) begin
      result_d = canon_nan;
    end else if (is_nan[0]) begin
      result_d = b_i;
    end else if (is_nan[1]) begin
      result_d = a_i;
    end else if (op_i == minmax_slice_pkg::MIN) begin
      result_d = a_lt_b ? a_i : b_i;
    end else begin
      result_d = a_lt_b ? b_i : a_i;
    end
    // FP16 results sit in the low half
    if (!is_fp32) begin
      result_d[31:16] = '0;
    end
    status_d    = '0;
    status_d.nv = |is_snan;
  end

  // ---------------------------------------------------------------------------
  // Output stage
  // ---------------------------------------------------------------------------
  assign in_ready_o = ~valid_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_q <= result_d;
      status_q <= status_d;
      aux_q    <= aux_i;
    end
  end

  assign result_o    = result_q;
  assign status_o    = status_q;
  assign aux_o       = aux_q;
  assign out_valid_o = valid_q;

endmodule

// ==== slice_result_pack.sv ====
// Result packer for the min/max slice
// Builds the output word from the lane results and merges their flags
`timescale 1ns/1ps

module slice_result_pack (
  input  logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane0_result_i,
  input  logic [fp_fmt_pkg::FP16_WIDTH-1:0]        lane1_result_i,
  input  fp_fmt_pkg::status_t                      lane0_status_i,
  input  fp_fmt_pkg::status_t                      lane1_status_i,
  input  logic                                     lane1_valid_i,
  input  minmax_slice_pkg::aux_t                   aux_i,
  output fp_fmt_pkg::fp_word_u                     result_o,
  output fp_fmt_pkg::status_t                      status_o
);

  logic                lane1_used;
  fp_fmt_pkg::status_t lane1_status;

  // Lane 1 only contributes to a vectorial FP16 result
  assign lane1_used = lane1_valid_i & aux_i.vectorial;

  // ---------------------------------------------------------------------------
  // Data packing
  // ---------------------------------------------------------------------------
  always_comb begin
    if (aux_i.fmt == fp_fmt_pkg::FP32) begin
      result_o.fp32 = lane0_result_i;
    end else begin
      result_o.fp16.lo = lane0_result_i[fp_fmt_pkg::FP16_WIDTH-1:0];
      // Scalar FP16 or an idle upper lane gets NaN-boxed
      if (lane1_used) begin
        result_o.fp16.hi = lane1_result_i;
      end else begin
        result_o.fp16.hi = '1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Status collapse
  // ---------------------------------------------------------------------------
  assign lane1_status = lane1_used ? lane1_status_i : '0;
  assign status_o     = lane0_status_i | lane1_status;

endmodule

// ==== fp_minmax_slice.sv ====
// Packed-SIMD floating-point min/max slice
// Scalar FP32, NaN-boxed scalar FP16 and two-lane vectorial FP16
`timescale 1ns/1ps

module fp_minmax_slice (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic [minmax_slice_pkg::SLICE_WIDTH-1:0] op_a_i,
  input  logic [minmax_slice_pkg::SLICE_WIDTH-1:0] op_b_i,
  input  minmax_slice_pkg::minmax_op_e             op_i,
  input  fp_fmt_pkg::fp_format_e                   fmt_i,
  input  logic                                     vectorial_i,
  input  logic                                     in_valid_i,
  output logic                                     in_ready_o,
  output logic [minmax_slice_pkg::SLICE_WIDTH-1:0] result_o,
  output fp_fmt_pkg::status_t                      status_o,
  output logic                                     out_valid_o,
  input  logic                                     out_ready_i,
  output logic                                     busy_o
);

  logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane0_a;
  logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane0_b;
  logic [fp_fmt_pkg::FP16_WIDTH-1:0]        lane1_a;
  logic [fp_fmt_pkg::FP16_WIDTH-1:0]        lane1_b;

  logic [minmax_slice_pkg::NUM_LANES-1:0]   lane_in_valid;
  logic [minmax_slice_pkg::NUM_LANES-1:0]   lane_in_ready;
  logic [minmax_slice_pkg::NUM_LANES-1:0]   lane_out_valid;
  logic [minmax_slice_pkg::NUM_LANES-1:0]   lane_out_ready;

  logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane0_result;
  logic [minmax_slice_pkg::SLICE_WIDTH-1:0] lane1_result;
  fp_fmt_pkg::status_t                      lane0_status;
  fp_fmt_pkg::status_t                      lane1_status;

  logic                                     vectorial_op;
  minmax_slice_pkg::aux_t                   aux_data;
  minmax_slice_pkg::aux_t                   lane0_aux;
  fp_fmt_pkg::fp_word_u                     packed_result;

  // ---------------------------------------------------------------------------
  // Input side
  // ---------------------------------------------------------------------------
  assign vectorial_op       = vectorial_i & (fmt_i == fp_fmt_pkg::FP16);
  assign aux_data.fmt       = fmt_i;
  assign aux_data.vectorial = vectorial_op;

  // Upper lane only starts for vectorial work
  assign lane_in_valid[0] = in_valid_i;
  assign lane_in_valid[1] = in_valid_i & vectorial_op;
  assign in_ready_o       = lane_in_ready[0];

  slice_operand_split u_split (
    .op_a_i      ( op_a_i       ),
    .op_b_i      ( op_b_i       ),
    .fmt_i       ( fmt_i        ),
    .vectorial_i ( vectorial_op ),
    .lane0_a_o   ( lane0_a      ),
    .lane0_b_o   ( lane0_b      ),
    .lane1_a_o   ( lane1_a      ),
    .lane1_b_o   ( lane1_b      )
  );

  // ---------------------------------------------------------------------------
  // Lanes
  // ---------------------------------------------------------------------------
  fp_minmax_lane #(
    .HasFp32 ( 1'b1 )
  ) lane0 (
    .clk_i       ( clk_i             ),
    .arst_n_i    ( arst_n_i          ),
    .a_i         ( lane0_a           ),
    .b_i         ( lane0_b           ),
    .op_i        ( op_i              ),
    .fmt_i       ( fmt_i             ),
    .aux_i       ( aux_data          ),
    .in_valid_i  ( lane_in_valid[0]  ),
    .in_ready_o  ( lane_in_ready[0]  ),
    .result_o    ( lane0_result      ),
    .status_o    ( lane0_status      ),
    .aux_o       ( lane0_aux         ),
    .out_valid_o ( lane_out_valid[0] ),
    .out_ready_i ( lane_out_ready[0] )
  );

  // Lane 1 holds only FP16 halves, its side information is not needed
  fp_minmax_lane #(
    .HasFp32 ( 1'b0 )
  ) lane1 (
    .clk_i       ( clk_i              ),
    .arst_n_i    ( arst_n_i           ),
    .a_i         ( {16'h0000, lane1_a} ),
    .b_i         ( {16'h0000, lane1_b} ),
    .op_i        ( op_i               ),
    .fmt_i       ( fmt_i              ),
    .aux_i       ( 2'b00              ),
    .in_valid_i  ( lane_in_valid[1]   ),
    .in_ready_o  ( lane_in_ready[1]   ),
    .result_o    ( lane1_result       ),
    .status_o    ( lane1_status       ),
    .aux_o       (                    ),
    .out_valid_o ( lane_out_valid[1]  ),
    .out_ready_i ( lane_out_ready[1]  )
  );

  // Registered vectorial flag decides whether lane 1 is drained
  assign lane_out_ready[0] = out_ready_i;
  assign lane_out_ready[1] = out_ready_i & lane0_aux.vectorial;

  // ---------------------------------------------------------------------------
  // Output side
  // ---------------------------------------------------------------------------
  slice_result_pack u_pack (
    .lane0_result_i ( lane0_result                              ),
    .lane1_result_i ( lane1_result[fp_fmt_pkg::FP16_WIDTH-1:0] ),
    .lane0_status_i ( lane0_status                              ),
    .lane1_status_i ( lane1_status                              ),
    .lane1_valid_i  ( lane_out_valid[1]                         ),
    .aux_i          ( lane0_aux                                 ),
    .result_o       ( packed_result                             ),
    .status_o       ( status_o                                  )
  );

  assign result_o    = packed_result;
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_out_valid;

endmodule

// ==== tb_minmax_model.svh ====
// Reference model for the min/max slice testbench
// Expected RISC-V FMIN/FMAX results for FP32, boxed FP16 and paired FP16
`ifndef TB_MINMAX_MODEL_SVH
`define TB_MINMAX_MODEL_SVH

// Min or max of two w-bit values held in the low bits, with the invalid flag
function automatic void minmax_one(input logic [31:0] a, input logic [31:0] b, input int w,
                                   input bit is_max, output logic [31:0] res, output bit nv);
  int          man_w;
  logic [31:0] mask;
  logic [31:0] fmask;
  bit          a_nan;
  bit          b_nan;
  logic [32:0] ka;
  logic [32:0] kb;
  man_w = (w == 32) ? 23 : 10;
  mask  = (32'd1 << (w - 1)) - 32'd1;
  fmask = (32'd1 << man_w) - 32'd1;
  a_nan = (((a & mask) >> man_w) == (mask >> man_w)) && ((a & fmask) != 0);
  b_nan = (((b & mask) >> man_w) == (mask >> man_w)) && ((b & fmask) != 0);
  // Quiet bit is the top fraction bit
  nv    = (a_nan && !a[man_w-1]) || (b_nan && !b[man_w-1]);
  // Sign-magnitude mapped onto an unsigned key, -0 lands just below +0
  ka = a[w-1] ? 33'h1_0000_0000 - 33'd1 - {1'b0, a & mask} : 33'h1_0000_0000 + {1'b0, a & mask};
  kb = b[w-1] ? 33'h1_0000_0000 - 33'd1 - {1'b0, b & mask} : 33'h1_0000_0000 + {1'b0, b & mask};
  if (a_nan && b_nan) res = (w == 32) ? 32'h7fc0_0000 : 32'h0000_7e00;
  else if (a_nan) res = b;
  else if (b_nan) res = a;
  else if (is_max) res = (ka >= kb) ? a : b;
  else res = (ka <= kb) ? a : b;
endfunction

// Expected output word and flags for one operation
function automatic void expected_word(input logic [31:0] a, input logic [31:0] b,
                                      input bit is_max, input bit fp16, input bit vec,
                                      output logic [31:0] res, output logic [4:0] st);
  logic [31:0] lo;
  logic [31:0] hi;
  logic [15:0] a16;
  logic [15:0] b16;
  bit          nv_lo;
  bit          nv_hi;
  nv_hi = 1'b0;
  hi    = 32'h0000_ffff;
  a16   = a[15:0];
  b16   = b[15:0];
  if (!fp16) begin
    minmax_one(a, b, 32, is_max, res, nv_lo);
  end else begin
    if (vec) begin
      minmax_one({16'd0, a[31:16]}, {16'd0, b[31:16]}, 16, is_max, hi, nv_hi);
    end else begin
      // Missing all-ones box reads as the canonical NaN
      if (a[31:16] != 16'hffff) a16 = 16'h7e00;
      if (b[31:16] != 16'hffff) b16 = 16'h7e00;
    end
    minmax_one({16'd0, a16}, {16'd0, b16}, 16, is_max, lo, nv_lo);
    res = {hi[15:0], lo[15:0]};
  end
  st = {nv_lo | nv_hi, 4'b0000};
endfunction

`endif

// ==== tb_fp_minmax_slice.sv ====
// Testbench for the packed-SIMD min/max slice
// Random and directed FP32/FP16 traffic checked against a reference model
`timescale 1ns/1ps

module tb_fp_minmax_slice;

  localparam int N_FP32 = 40;
  localparam int N_FP16 = 40;
  localparam int N_VEC  = 40;
  localparam int N_NAN  = 24;
  localparam int N_BP   = 60;
  // Reset, about three cycles per item, more under back-pressure, plus margin
  localparam int MAX_CYCLES = 16 + 3 * (N_FP32 + N_FP16 + N_VEC + N_NAN + 4) + 8 * N_BP + 200;

  logic                         clk_i;
  logic                         arst_n_i;
  logic [31:0]                  op_a_i;
  logic [31:0]                  op_b_i;
  minmax_slice_pkg::minmax_op_e op_i;
  fp_fmt_pkg::fp_format_e       fmt_i;
  logic                         vectorial_i;
  logic                         in_valid_i;
  logic                         in_ready_o;
  logic [31:0]                  result_o;
  fp_fmt_pkg::status_t          status_o;
  logic                         out_valid_o;
  logic                         out_ready_i;
  logic                         busy_o;

  logic [31:0] exp_res_q[$];
  logic [4:0]  exp_st_q[$];
  logic [31:0] exp_res;
  logic [4:0]  exp_st;
  int          errors;
  int          checks;
  int          items;
  int          tests;
  int          ready_pct;
  int          cycles;
  int unsigned seed_ret;

  `include "tb_minmax_model.svh"

  fp_minmax_slice dut0 (.*);

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic flag_violation(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // --------------------------------------------------------------------------
  // Protocol properties
  // --------------------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_valid_i && in_ready_o |=> out_valid_o)
    else flag_violation("out_valid_o did not rise one cycle after an accepted input");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(status_o))
    else flag_violation("a held output changed before it was taken");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |-> !in_ready_o)
    else flag_violation("in_ready_o stayed high while the full stage was stalled");
  assert property (@(posedge clk_i) disable iff (!arst_n_i) busy_o == out_valid_o)
    else flag_violation("busy_o does not follow the held item");

  // Falling edge sampling, all handshake signals are settled here
  always @(negedge clk_i) begin
    if (arst_n_i && out_valid_o && out_ready_i) begin
      if (exp_res_q.size() == 0) begin
        flag_violation("the slice produced an output with no input pending");
      end else begin
        exp_res = exp_res_q.pop_front();
        exp_st  = exp_st_q.pop_front();
        checks++;
        assert (result_o === exp_res && status_o === exp_st)
          else flag_mismatch($sformatf("result %h status %b, expected %h %b",
                                       result_o, status_o, exp_res, exp_st));
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  // Random w-bit value, biased towards signed zeros and NaNs
  function automatic logic [31:0] pick_value(input int w, input bit nan_only);
    logic [31:0] r;
    int          sel;
    r   = $urandom;
    sel = nan_only ? 1 + $urandom % 2 : $urandom % 6;
    case (sel)
      0: r = (w == 32) ? {r[31], 31'd0} : {16'd0, r[15], 15'd0};
      1: r = (w == 32) ? {r[31], 8'hff, 1'b1, r[21:0]} : {16'd0, r[15], 5'h1f, 1'b1, r[8:0]};
      2: r = (w == 32) ? {r[31], 8'hff, 1'b0, r[21:1], 1'b1}
                       : {16'd0, r[15], 5'h1f, 1'b0, r[8:1], 1'b1};
      default: r = (w == 32) ? r : {16'd0, r[15:0]};
    endcase
    return r;
  endfunction

  function automatic logic [31:0] make_operand(input bit fp16, input bit vec, input bit nan_only);
    logic [31:0] lo;
    logic [31:0] hi;
    if (!fp16) return pick_value(32, nan_only);
    lo = pick_value(16, nan_only);
    hi = pick_value(16, nan_only);
    // Scalar FP16 is mostly boxed, the rest carries a random upper half
    if (!vec) hi = ($urandom % 5 == 0) ? $urandom : 32'h0000_ffff;
    return {hi[15:0], lo[15:0]};
  endfunction

  // Presents one item and holds it until the slice takes it
  task automatic send(input logic [31:0] a, input logic [31:0] b, input bit is_max,
                      input bit fp16, input bit vec);
    logic [31:0] er;
    logic [4:0]  es;
    bit          taken;
    expected_word(a, b, is_max, fp16, vec, er, es);
    op_a_i      = a;
    op_b_i      = b;
    op_i        = is_max ? minmax_slice_pkg::MAX : minmax_slice_pkg::MIN;
    fmt_i       = fp16 ? fp_fmt_pkg::FP16 : fp_fmt_pkg::FP32;
    vectorial_i = vec;
    in_valid_i  = 1'b1;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      if (taken) begin
        exp_res_q.push_back(er);
        exp_st_q.push_back(es);
      end
      @(posedge clk_i);
      #10;
    end
    in_valid_i = 1'b0;
    items++;
  endtask

  // kind 0 FP32, 1 scalar FP16, 2 vectorial FP16, 3 NaN-only mix, 4 random mix
  task automatic run_test(input string name, input int n, input int kind, input int pct);
    int          err_start;
    bit          fp16;
    bit          vec;
    logic [31:0] a;
    logic [31:0] b;
    err_start = errors;
    items     = 0;
    ready_pct = pct;
    if (kind == 0) begin
      send(32'h8000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
      send(32'h8000_0000, 32'h0000_0000, 1'b1, 1'b0, 1'b0);
    end else if (kind == 3) begin
      // sNaN only in the upper lane, then sNaN against qNaN in FP32
      send({16'h7c01, 16'h3c00}, {16'h4000, 16'hbc00}, 1'b0, 1'b1, 1'b1);
      send(32'h7f80_0001, 32'h7fc0_0000, 1'b1, 1'b0, 1'b0);
    end
    for (int i = 0; i < n; i++) begin
      fp16 = (kind == 1) || (kind == 2) || (kind >= 3 && $urandom % 2 == 1);
      vec  = (kind == 2) || (kind >= 3 && $urandom % 2 == 1);
      a    = make_operand(fp16, vec, kind == 3);
      b    = make_operand(fp16, vec, kind == 3);
      send(a, b, $urandom % 2 == 1, fp16, vec);
      if (kind == 4 && $urandom % 4 == 0) begin
        @(posedge clk_i);
        #10;
      end
    end
    while (exp_res_q.size() != 0) begin
      @(posedge clk_i);
    end
    #10;
    tests++;
    $display("Test %-12s %0d items, %0d errors", name, items, errors - err_start);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    @(posedge arst_n_i);
    forever begin
      @(posedge clk_i);
      #10 out_ready_i = ($urandom % 100) < ready_pct;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run timed out after %0d cycles", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    seed_ret    = $urandom(32'ha8574cd2);
    arst_n_i    = 1'b0;
    op_a_i      = '0;
    op_b_i      = '0;
    op_i        = minmax_slice_pkg::MIN;
    fmt_i       = fp_fmt_pkg::FP32;
    vectorial_i = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    ready_pct   = 100;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    repeat (16) @(posedge clk_i);
    #10 arst_n_i = 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o)
      else flag_violation("outputs were not idle after reset");
    @(posedge clk_i);
    #10;
    run_test("reset_fp32", N_FP32, 0, 100);
    run_test("fp16_boxed", N_FP16, 1, 100);
    run_test("fp16_vector", N_VEC, 2, 100);
    run_test("nan_rules", N_NAN, 3, 100);
    run_test("backpressure", N_BP, 4, 50);
    $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== fp_minmax_slice.f ====
+incdir+.
fp_fmt_pkg.sv
minmax_slice_pkg.sv
slice_operand_split.sv
fp_minmax_lane.sv
slice_result_pack.sv
fp_minmax_slice.sv
tb_fp_minmax_slice.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the min/max slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fp_minmax_slice -f fp_minmax_slice.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
